// File: common/ifu_pkg.sv
//////////////////////////////
// widths and constants shared by the fetch stage and the icache
// line geometry is fixed here, set count comes from the top level
//////////////////////////////
package ifu_pkg;

    // address and pc width
    parameter int XLEN = 64;

    // one rv64 instruction word
    parameter int INSTR_W = 32;

    // cache line, four instruction words
    parameter int LINE_W = 128;

    // byte offset bits within one line
    parameter int OFFSET_W = 4;

    // instruction words held by a line
    parameter int WORDS_PER_LINE = LINE_W / INSTR_W;

    // word select field of the pc, bits 3:2
    parameter int WORD_LSB = 2;
    parameter int WORD_SEL_W = OFFSET_W - WORD_LSB;

    // first fetch address after reset
    parameter logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

endpackage

// File: common/cache_lookup_if.sv
//////////////////////////////
// lookup and refill bus between fetch unit, ways and controller
// hit and way_line are driven one slice per way
//////////////////////////////
`timescale 1ns/1ns

interface cache_lookup_if #(
    parameter int NUM_WAYS = 2,
    parameter int NUM_SETS = 16
);
    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ifu_pkg::XLEN - INDEX_W - ifu_pkg::OFFSET_W;

    // lookup request from the fetch unit
    logic                         lookup_valid;
    logic [INDEX_W-1:0]           lookup_index;
    logic [TAG_W-1:0]             lookup_tag;

    // refill from the controller, one-hot way select
    logic [NUM_WAYS-1:0]          refill_we;
    logic [ifu_pkg::LINE_W-1:0]   refill_line;

    // nets, since every way drives only its own bit and slice
    wire [NUM_WAYS-1:0]                       hit;
    wire [NUM_WAYS-1:0][ifu_pkg::LINE_W-1:0]  way_line;

    modport fetch (output lookup_valid, lookup_index, lookup_tag);

    modport way (
        input  lookup_valid, lookup_index, lookup_tag, refill_we, refill_line,
        output hit, way_line
    );

    modport ctrl (
        input  lookup_valid, lookup_index, lookup_tag, hit, way_line,
        output refill_we, refill_line
    );

endinterface

// File: hdl/fetch_unit.sv
//////////////////////////////
// one fetch in flight, redirects during a fetch are dropped
// pc must stay put until the cache answers
//////////////////////////////
`timescale 1ns/1ns

module fetch_unit #(
    parameter int NUM_SETS = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [ifu_pkg::XLEN-1:0]     dnpc_i,
    input  logic                         dnpc_valid_i,
    input  logic                         block_i,
    input  logic                         id_busy_i,
    input  logic                         rsp_valid_i,
    input  logic [ifu_pkg::LINE_W-1:0]   rsp_line_i,
    output logic [ifu_pkg::XLEN-1:0]     pc_o,
    output logic [ifu_pkg::INSTR_W-1:0]  instr_o,
    output logic                         inst_valid_o,
    cache_lookup_if.fetch                lk
);
    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ifu_pkg::XLEN - INDEX_W - ifu_pkg::OFFSET_W;

    logic                             issue_q;
    logic                             busy_q;
    logic                             accept;
    logic [ifu_pkg::WORD_SEL_W-1:0]   word_sel;

    // redirect only when nothing is in flight and the pipe is not blocked
    assign accept = dnpc_valid_i && !block_i && !busy_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_o    <= ifu_pkg::RESET_PC;
            // reset pc gets fetched as soon as rst drops
            issue_q <= 1'b1;
            busy_q  <= 1'b1;
        end else begin
            issue_q <= accept;
            if (accept) begin
                pc_o   <= dnpc_i;
                busy_q <= 1'b1;
            end else if (rsp_valid_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // lookup fields straight from the held pc
    assign lk.lookup_valid = issue_q;
    assign lk.lookup_index = pc_o[ifu_pkg::OFFSET_W +: INDEX_W];
    assign lk.lookup_tag   = pc_o[ifu_pkg::XLEN-1 -: TAG_W];

    // which 32-bit word of the line
    assign word_sel = pc_o[ifu_pkg::WORD_LSB +: ifu_pkg::WORD_SEL_W];

    // valid flag, held while decode is busy
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_valid_o <= 1'b0;
        end else if (rsp_valid_i) begin
            inst_valid_o <= 1'b1;
        end else if (!id_busy_i) begin
            inst_valid_o <= 1'b0;
        end
    end

    // instruction word, only loaded on a response so it stays stable on hold
    always_ff @(posedge clk) begin
        if (rsp_valid_i) begin
            instr_o <= rsp_line_i[word_sel*ifu_pkg::INSTR_W +: ifu_pkg::INSTR_W];
        end
    end

endmodule

// File: icache/icache_way.sv
//////////////////////////////
// one way of the icache, hit and line come out registered
// refill uses the index and tag still held on the lookup bus
//////////////////////////////
`timescale 1ns/1ns

module icache_way #(
    parameter int NUM_SETS = 16,
    parameter int WAY      = 0
) (
    input  logic      clk,
    input  logic      rst,
    cache_lookup_if.way lk
);
    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ifu_pkg::XLEN - INDEX_W - ifu_pkg::OFFSET_W;

    logic [NUM_SETS-1:0]          valid_q;
    logic [TAG_W-1:0]             tag_mem  [NUM_SETS];
    logic [ifu_pkg::LINE_W-1:0]   data_mem [NUM_SETS];
    logic                         hit_q;
    logic [ifu_pkg::LINE_W-1:0]   line_q;
    logic                         tag_match;

    // stored tag against the requested one
    assign tag_match = valid_q[lk.lookup_index] &&
                       (tag_mem[lk.lookup_index] == lk.lookup_tag);

    // valid bits and hit flag
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            hit_q   <= 1'b0;
        end else begin
            if (lk.lookup_valid) begin
                hit_q <= tag_match;
            end
            if (lk.refill_we[WAY]) begin
                valid_q[lk.lookup_index] <= 1'b1;
            end
        end
    end

    // tag and line arrays plus the read register
    always_ff @(posedge clk) begin
        if (lk.refill_we[WAY]) begin
            tag_mem[lk.lookup_index]  <= lk.lookup_tag;
            data_mem[lk.lookup_index] <= lk.refill_line;
        end
        if (lk.lookup_valid) begin
            line_q <= data_mem[lk.lookup_index];
        end
    end

    // this way's bit and slice only
    assign lk.hit[WAY]      = hit_q;
    assign lk.way_line[WAY] = line_q;

endmodule

// File: icache/icache_ctrl.sv
//////////////////////////////
// miss fsm, one miss at a time, per-set round robin victim
// memory side is a level request ended by a one-cycle ready
//////////////////////////////
`timescale 1ns/1ns

module icache_ctrl #(
    parameter int NUM_WAYS = 2,
    parameter int NUM_SETS = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    cache_lookup_if.ctrl                 lk,
    output logic [ifu_pkg::XLEN-1:0]     mem_addr_o,
    output logic                         mem_req_o,
    input  logic [ifu_pkg::LINE_W-1:0]   mem_line_i,
    input  logic                         mem_ready_i,
    output logic                         rsp_valid_o,
    output logic [ifu_pkg::LINE_W-1:0]   rsp_line_o
);
    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ifu_pkg::XLEN - INDEX_W - ifu_pkg::OFFSET_W;
    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_REFILL
    } state_t;

    state_t                           state_q;
    logic                             cmp_q;
    logic [TAG_W-1:0]                 tag_q;
    logic [INDEX_W-1:0]               idx_q;
    logic [NUM_SETS-1:0][WAY_W-1:0]   rr_q;
    logic [WAY_W-1:0]                 rr_next;
    logic [NUM_WAYS-1:0]              victim_we;
    logic [ifu_pkg::LINE_W-1:0]       hit_line;

    // request fields kept for the miss address and the victim pointer
    always_ff @(posedge clk) begin
        if (lk.lookup_valid) begin
            tag_q <= lk.lookup_tag;
            idx_q <= lk.lookup_index;
        end
    end

    // line of whichever way hit, at most one does
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (lk.hit[w]) begin
                hit_line = lk.way_line[w];
            end
        end
    end

    // victim is the set's pointer, wraps at the last way
    always_comb begin
        victim_we = '0;
        victim_we[rr_q[idx_q]] = 1'b1;
        if (rr_q[idx_q] == WAY_W'(NUM_WAYS - 1)) begin
            rr_next = '0;
        end else begin
            rr_next = rr_q[idx_q] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= S_IDLE;
            cmp_q        <= 1'b0;
            mem_req_o    <= 1'b0;
            rsp_valid_o  <= 1'b0;
            lk.refill_we <= '0;
            rr_q         <= '0;
        end else begin
            // ways compare one cycle after the lookup
            cmp_q       <= lk.lookup_valid;
            rsp_valid_o <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (cmp_q) begin
                        if (|lk.hit) begin
                            rsp_valid_o <= 1'b1;
                        end else begin
                            mem_req_o <= 1'b1;
                            state_q   <= S_REQ;
                        end
                    end
                end
                S_REQ: begin
                    // hold the request until memory answers
                    if (mem_ready_i) begin
                        mem_req_o    <= 1'b0;
                        lk.refill_we <= victim_we;
                        state_q      <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    // way written on this edge, answer goes out next cycle
                    lk.refill_we <= '0;
                    rsp_valid_o  <= 1'b1;
                    rr_q[idx_q]  <= rr_next;
                    state_q      <= S_IDLE;
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && cmp_q) begin
            rsp_line_o <= hit_line;
            mem_addr_o <= {tag_q, idx_q, {ifu_pkg::OFFSET_W{1'b0}}};
        end
        if (state_q == S_REQ && mem_ready_i) begin
            lk.refill_line <= mem_line_i;
        end
        // memory line forwarded to the fetch unit
        if (state_q == S_REFILL) begin
            rsp_line_o <= lk.refill_line;
        end
    end

endmodule

// File: hdl/ifu_top.sv
//////////////////////////////
// fetch stage with its set associative icache
// memory needs line-aligned reads, one at a time
//////////////////////////////
`timescale 1ns/1ns

module ifu_top #(
    parameter int NUM_WAYS = 2,
    parameter int NUM_SETS = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [ifu_pkg::XLEN-1:0]     dnpc_i,
    input  logic                         dnpc_valid_i,
    input  logic                         block_i,
    input  logic                         id_busy_i,
    output logic [ifu_pkg::XLEN-1:0]     pc_o,
    output logic [ifu_pkg::INSTR_W-1:0]  instr_o,
    output logic                         inst_valid_o,
    output logic [ifu_pkg::XLEN-1:0]     mem_addr_o,
    output logic                         mem_req_o,
    input  logic [ifu_pkg::LINE_W-1:0]   mem_line_i,
    input  logic                         mem_ready_i
);
    logic                         rsp_valid;
    logic [ifu_pkg::LINE_W-1:0]   rsp_line;

    cache_lookup_if #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_SETS (NUM_SETS)
    ) lk_if ();

    fetch_unit #(
        .NUM_SETS (NUM_SETS)
    ) fetch_unit_i (
        .clk          (clk),
        .rst          (rst),
        .dnpc_i       (dnpc_i),
        .dnpc_valid_i (dnpc_valid_i),
        .block_i      (block_i),
        .id_busy_i    (id_busy_i),
        .rsp_valid_i  (rsp_valid),
        .rsp_line_i   (rsp_line),
        .pc_o         (pc_o),
        .instr_o      (instr_o),
        .inst_valid_o (inst_valid_o),
        .lk           (lk_if.fetch)
    );

    // way array
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        icache_way #(
            .NUM_SETS (NUM_SETS),
            .WAY      (w)
        ) way_i (
            .clk (clk),
            .rst (rst),
            .lk  (lk_if.way)
        );
    end

    icache_ctrl #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_SETS (NUM_SETS)
    ) icache_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .lk          (lk_if.ctrl),
        .mem_addr_o  (mem_addr_o),
        .mem_req_o   (mem_req_o),
        .mem_line_i  (mem_line_i),
        .mem_ready_i (mem_ready_i),
        .rsp_valid_o (rsp_valid),
        .rsp_line_o  (rsp_line)
    );

endmodule

// File: testbench/tb_clk_gen.sv
//////////////////////////////
// 4 ns clock, reset high for two rising edges
//////////////////////////////
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset drops on the second edge, same timing as other stimulus
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// File: testbench/ifu_asserts.sv
//////////////////////////////
// memory and response protocol checks, bound into icache_ctrl
//////////////////////////////
`timescale 1ns/1ns

module ifu_asserts (
    input logic                       clk,
    input logic                       rst,
    input logic [ifu_pkg::XLEN-1:0]   mem_addr_i,
    input logic                       mem_req_i,
    input logic                       mem_ready_i,
    input logic                       rsp_valid_i
);

    // request address is always a line base
    addr_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_req_i |-> (mem_addr_i[ifu_pkg::OFFSET_W-1:0] == '0))
        else $error("memory request address is not line aligned");

    // address held for the whole request
    addr_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req_i && $past(mem_req_i)) |-> $stable(mem_addr_i))
        else $error("memory address changed during a request");

    // request ends right after the ready pulse
    req_drop: assert property (@(posedge clk) disable iff (rst)
        mem_ready_i |=> !mem_req_i)
        else $error("memory request still high after ready");

    // one response pulse per fetch
    rsp_single: assert property (@(posedge clk) disable iff (rst)
        rsp_valid_i |=> !rsp_valid_i)
        else $error("response valid high on two cycles in a row");

endmodule

bind icache_ctrl ifu_asserts ifu_asserts_i (
    .clk         (clk),
    .rst         (rst),
    .mem_addr_i  (mem_addr_o),
    .mem_req_i   (mem_req_o),
    .mem_ready_i (mem_ready_i),
    .rsp_valid_i (rsp_valid_o)
);

// File: testbench/ifu_tb.sv
//////////////////////////////
// directed tests for the fetch stage, memory words = address ^ 5a5a5a5a
// one redirect at a time, each waits for inst_valid_o
//////////////////////////////
`timescale 1ns/1ns

module ifu_tb;

    localparam int TIMEOUT_CYCLES = 2000;
    // accept edge to the first edge that samples inst_valid_o high
    localparam int HIT_CYCLES = 4;
    localparam logic [63:0] BLOCK_PC = 64'h0000_0000_8000_0200;
    localparam logic [63:0] HOLD_PC = 64'h0000_0000_8000_0008;
    // same set 5, three different tags
    localparam logic [63:0] SET_A = 64'h0000_0000_8000_1054;
    localparam logic [63:0] SET_B = 64'h0000_0000_8000_2058;
    localparam logic [63:0] SET_C = 64'h0000_0000_8000_305c;

    logic          clk;
    logic          rst;
    logic [63:0]   dnpc_i;
    logic          dnpc_valid_i;
    logic          block_i;
    logic          id_busy_i;
    logic [63:0]   pc_o;
    logic [31:0]   instr_o;
    logic          inst_valid_o;
    logic [63:0]   mem_addr_o;
    logic          mem_req_o;
    logic [127:0]  mem_line_i;
    logic          mem_ready_i;

    // memory model state
    logic          mem_pending;
    int            mem_wait;
    logic [63:0]   req_addr;
    int            req_count;
    int            lat_tab [64];
    logic [63:0]   sweep_addr [12];

    int            error_count = 0;
    int            cycle_count = 0;

    tb_clk_gen clk_gen_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    ifu_top #(
        .NUM_WAYS (2),
        .NUM_SETS (16)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .dnpc_i       (dnpc_i),
        .dnpc_valid_i (dnpc_valid_i),
        .block_i      (block_i),
        .id_busy_i    (id_busy_i),
        .pc_o         (pc_o),
        .instr_o      (instr_o),
        .inst_valid_o (inst_valid_o),
        .mem_addr_o   (mem_addr_o),
        .mem_req_o    (mem_req_o),
        .mem_line_i   (mem_line_i),
        .mem_ready_i  (mem_ready_i)
    );

    // word of memory at a given byte address
    function automatic logic [31:0] expected_instr(input logic [63:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_5a5a;
    endfunction

    function automatic logic [127:0] line_at(input logic [63:0] addr);
        logic [127:0] line;
        for (int k = 0; k < 4; k++) begin
            line[k*32 +: 32] = ({addr[31:4], 4'h0} + 32'(k * 4)) ^ 32'h5a5a_5a5a;
        end
        return line;
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // memory, latency 1 to 8 cycles from the table
    initial begin
        mem_ready_i = 1'b0;
        mem_line_i  = '0;
        mem_pending = 1'b0;
        mem_wait    = 0;
        req_addr    = '0;
        req_count   = 0;
        forever begin
            @(posedge clk);
            mem_ready_i <= 1'b0;
            if (rst) begin
                mem_pending <= 1'b0;
            end else if (mem_pending) begin
                if (mem_wait == 0) begin
                    mem_ready_i <= 1'b1;
                    mem_line_i  <= line_at(req_addr);
                    mem_pending <= 1'b0;
                end else begin
                    mem_wait <= mem_wait - 1;
                end
            end else if (mem_req_o && !mem_ready_i) begin
                // new request, ready edge itself is skipped
                mem_pending <= 1'b1;
                req_addr    <= mem_addr_o;
                mem_wait    <= lat_tab[req_count[5:0]];
                req_count   <= req_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // one redirect, waits for the word and checks pc and instruction
    task automatic fetch_word(input logic [63:0] addr, output int lat);
        @(posedge clk);
        dnpc_i       <= addr;
        dnpc_valid_i <= 1'b1;
        // pc loads on this edge
        @(posedge clk);
        dnpc_valid_i <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (inst_valid_o !== 1'b1);
        if (pc_o !== addr) begin
            report_error($sformatf("pc %h, expected %h", pc_o, addr));
        end
        if (instr_o !== expected_instr(addr)) begin
            report_error($sformatf("instr %h at %h, expected %h",
                                   instr_o, addr, expected_instr(addr)));
        end
    endtask

    task automatic fetch_after_reset();
        do begin
            @(posedge clk);
        end while (inst_valid_o !== 1'b1);
        if (req_count != 1) begin
            report_error($sformatf("%0d memory requests after reset, expected 1", req_count));
        end
        if (req_addr !== ifu_pkg::RESET_PC) begin
            report_error($sformatf("first request to %h", req_addr));
        end
        if (pc_o !== ifu_pkg::RESET_PC) begin
            report_error($sformatf("pc %h after reset", pc_o));
        end
        if (instr_o !== expected_instr(ifu_pkg::RESET_PC)) begin
            report_error($sformatf("reset instr %h", instr_o));
        end
    endtask

    // rest of the reset line, all hits
    task automatic hit_same_line();
        int reqs;
        int lat;
        logic [63:0] addr;
        reqs = req_count;
        for (int i = 1; i < 4; i++) begin
            addr = ifu_pkg::RESET_PC + 64'(i * 4);
            fetch_word(addr, lat);
            if (lat != HIT_CYCLES) begin
                report_error($sformatf("hit at %h took %0d cycles", addr, lat));
            end
        end
        if (req_count != reqs) begin
            report_error($sformatf("%0d requests on line hits", req_count - reqs));
        end
    endtask

    // set 5 with two ways, A B C A leaves C and A resident
    task automatic replace_round_robin();
        int reqs;
        int lat;
        reqs = req_count;
        fetch_word(SET_A, lat);
        fetch_word(SET_B, lat);
        fetch_word(SET_C, lat);
        fetch_word(SET_A, lat);
        if (req_count != reqs + 4) begin
            report_error($sformatf("%0d misses in A B C A, expected 4", req_count - reqs));
        end
        reqs = req_count;
        fetch_word(SET_C, lat);
        if (lat != HIT_CYCLES) begin
            report_error($sformatf("C not a hit, %0d cycles", lat));
        end
        fetch_word(SET_A, lat);
        if (lat != HIT_CYCLES) begin
            report_error($sformatf("A not a hit, %0d cycles", lat));
        end
        if (req_count != reqs) begin
            report_error("memory request on a resident line");
        end
        // B was the victim of the second A
        fetch_word(SET_B, lat);
        if (req_count != reqs + 1) begin
            report_error("evicted line B did not miss");
        end
    endtask

    task automatic hold_while_blocked();
        logic [63:0] pc_before;
        int reqs;
        int lat;
        pc_before = pc_o;
        reqs = req_count;
        @(posedge clk);
        block_i <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            dnpc_i       <= BLOCK_PC;
            dnpc_valid_i <= (i % 2 == 0);
            if (pc_o !== pc_before) begin
                report_error($sformatf("pc moved to %h while blocked", pc_o));
            end
            if (inst_valid_o !== 1'b0) begin
                report_error("inst_valid_o high while blocked");
            end
            if (mem_req_o !== 1'b0 || req_count != reqs) begin
                report_error("memory request while blocked");
            end
        end
        @(posedge clk);
        dnpc_valid_i <= 1'b0;
        if (pc_o !== pc_before) begin
            report_error($sformatf("pc moved to %h after blocked redirect", pc_o));
        end
        @(posedge clk);
        block_i <= 1'b0;
        fetch_word(BLOCK_PC, lat);
        if (req_count != reqs + 1) begin
            report_error("redirect after release did not fetch its line");
        end
    endtask

    task automatic hold_for_decode();
        logic [31:0] held;
        int lat;
        @(posedge clk);
        id_busy_i <= 1'b1;
        fetch_word(HOLD_PC, lat);
        held = instr_o;
        repeat (5) begin
            @(posedge clk);
            if (inst_valid_o !== 1'b1) begin
                report_error("inst_valid_o dropped while decode busy");
            end
            if (instr_o !== held) begin
                report_error($sformatf("instr changed to %h while held", instr_o));
            end
        end
        id_busy_i <= 1'b0;
        // decode free on the next edge, flag low after it
        @(posedge clk);
        @(posedge clk);
        if (inst_valid_o !== 1'b0) begin
            report_error("inst_valid_o still high after decode release");
        end
    endtask

    task automatic sweep_random_pcs();
        int lat;
        for (int i = 0; i < 12; i++) begin
            fetch_word(sweep_addr[i], lat);
        end
    endtask

    initial begin
        void'($urandom(32'hbfe8ab24));
        dnpc_i       = '0;
        dnpc_valid_i = 1'b0;
        block_i      = 1'b0;
        id_busy_i    = 1'b0;
        for (int i = 0; i < 64; i++) begin
            lat_tab[i] = int'($urandom % 8);
        end
        // word addresses in the first 1 KB above the reset pc
        for (int i = 0; i < 12; i++) begin
            sweep_addr[i] = ifu_pkg::RESET_PC + {52'd0, 10'($urandom % 256), 2'b00};
        end
        fetch_after_reset();
        hit_same_line();
        replace_round_robin();
        hold_while_blocked();
        hold_for_decode();
        sweep_random_pcs();
        $display("tests run: 6  errors: %0d", error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: flist.f
common/ifu_pkg.sv
common/cache_lookup_if.sv
hdl/fetch_unit.sv
icache/icache_way.sv
icache/icache_ctrl.sv
hdl/ifu_top.sv
testbench/tb_clk_gen.sv
testbench/ifu_asserts.sv
testbench/ifu_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f flist.f --top-module ifu_tb -o ifu_sim
	./obj_dir/ifu_sim | tee $(LOG)
	@if grep -q "\*\*\* FAILED \*\*\*" $(LOG); then exit 1; fi
	@if ! grep -q "\*\*\* PASSED \*\*\*" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
